/* scaler_geom_pkg.sv */
`default_nettype none

package scaler_geom_pkg;

    // ========================================
    // Pixel values
    // ========================================

    typedef logic [7:0] pixel_t;          // 8-bit grey

    localparam pixel_t pixel_black = 8'h00; // Fill outside the scaled window

    // ========================================
    // Framebuffer side, sized for 640x480
    // ========================================

    typedef logic [18:0] fb_addr_t;       // Linear, raster order
    typedef logic [9:0]  fb_x_t;
    typedef logic [8:0]  fb_y_t;

    // ========================================
    // Source ROM side, sized for 160x120
    // ========================================

    typedef logic [14:0] src_addr_t;
    typedef logic [7:0]  src_x_t;
    typedef logic [6:0]  src_y_t;

endpackage

`default_nettype wire

/* scaler_ctrl_pkg.sv */
`default_nettype none

package scaler_ctrl_pkg;

    // Scale mode, sampled once per frame at start
    typedef enum logic [1:0] {
        mode_normal     = 2'd0, // 1:1 copy
        mode_half_avg   = 2'd1, // 0.5x, rounded mean of a 2x2 block
        mode_double_rep = 2'd2  // 2x, each source pixel covers 2x2 outputs
    } scale_mode_t;             // Code 3 behaves as normal

    // Number of ROM reads behind one output pixel
    typedef logic [2:0] tap_cnt_t;

    localparam tap_cnt_t taps_single = 3'd1;
    localparam tap_cnt_t taps_block  = 3'd4;

    function automatic tap_cnt_t mode_taps(input scale_mode_t mode);
        return (mode == mode_half_avg) ? taps_block : taps_single;
    endfunction

endpackage

`default_nettype wire

/* raster_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_scan #(
    parameter int fb_w = 640,
    parameter int fb_h = 480
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       clear,
    input  wire                       step,
    output scaler_geom_pkg::fb_x_t    fb_x,
    output scaler_geom_pkg::fb_y_t    fb_y,
    output scaler_geom_pkg::fb_addr_t fb_addr,
    output logic                      last
);

    localparam scaler_geom_pkg::fb_x_t x_max =
        scaler_geom_pkg::fb_x_t'(fb_w - 1);
    localparam scaler_geom_pkg::fb_addr_t addr_max =
        scaler_geom_pkg::fb_addr_t'(fb_w * fb_h - 1);

    assign last = (fb_addr == addr_max);

    // Address and x/y advance together, so no divide by fb_w is needed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fb_addr <= '0;
            fb_x    <= '0;
            fb_y    <= '0;
        end else if (clear) begin
            fb_addr <= '0;
            fb_x    <= '0;
            fb_y    <= '0;
        end else if (step) begin
            fb_addr <= fb_addr + 1'b1;
            if (fb_x == x_max) begin
                fb_x <= '0;             // Wrap to next line
                fb_y <= fb_y + 1'b1;
            end else begin
                fb_x <= fb_x + 1'b1;
            end
        end
    end

    // Controller must stop at the final address, never wrap past it
    a_no_step_past_end: assert property (
        @(posedge clk) disable iff (reset) step |-> !last
    ) else $error("raster_scan stepped past the last framebuffer address");

endmodule

`default_nettype wire

/* source_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module source_mapper #(
    parameter int src_w = 160,
    parameter int src_h = 120,
    parameter int fb_w  = 640,
    parameter int fb_h  = 480
) (
    input  wire scaler_geom_pkg::fb_x_t        fb_x,
    input  wire scaler_geom_pkg::fb_y_t        fb_y,
    input  wire scaler_ctrl_pkg::scale_mode_t  mode,
    output logic                               in_window,
    output scaler_geom_pkg::src_x_t            src_x,
    output scaler_geom_pkg::src_y_t            src_y
);

    // ========================================
    // Window size and centring offset per mode
    // ========================================

    localparam scaler_geom_pkg::fb_x_t w_nrm  = scaler_geom_pkg::fb_x_t'(src_w);
    localparam scaler_geom_pkg::fb_x_t w_half = scaler_geom_pkg::fb_x_t'(src_w / 2);
    localparam scaler_geom_pkg::fb_x_t w_dbl  = scaler_geom_pkg::fb_x_t'(src_w * 2);
    localparam scaler_geom_pkg::fb_y_t h_nrm  = scaler_geom_pkg::fb_y_t'(src_h);
    localparam scaler_geom_pkg::fb_y_t h_half = scaler_geom_pkg::fb_y_t'(src_h / 2);
    localparam scaler_geom_pkg::fb_y_t h_dbl  = scaler_geom_pkg::fb_y_t'(src_h * 2);

    localparam scaler_geom_pkg::fb_x_t x0_nrm  = scaler_geom_pkg::fb_x_t'((fb_w - src_w) / 2);
    localparam scaler_geom_pkg::fb_x_t x0_half = scaler_geom_pkg::fb_x_t'((fb_w - src_w / 2) / 2);
    localparam scaler_geom_pkg::fb_x_t x0_dbl  = scaler_geom_pkg::fb_x_t'((fb_w - src_w * 2) / 2);
    localparam scaler_geom_pkg::fb_y_t y0_nrm  = scaler_geom_pkg::fb_y_t'((fb_h - src_h) / 2);
    localparam scaler_geom_pkg::fb_y_t y0_half = scaler_geom_pkg::fb_y_t'((fb_h - src_h / 2) / 2);
    localparam scaler_geom_pkg::fb_y_t y0_dbl  = scaler_geom_pkg::fb_y_t'((fb_h - src_h * 2) / 2);

    scaler_geom_pkg::fb_x_t win_x0, win_w, rel_x;
    scaler_geom_pkg::fb_y_t win_y0, win_h, rel_y;

    always_comb begin
        win_x0 = x0_nrm;        // Normal, also covers code 3
        win_y0 = y0_nrm;
        win_w  = w_nrm;
        win_h  = h_nrm;
        case (mode)
            scaler_ctrl_pkg::mode_half_avg: begin
                win_x0 = x0_half;
                win_y0 = y0_half;
                win_w  = w_half;
                win_h  = h_half;
            end
            scaler_ctrl_pkg::mode_double_rep: begin
                win_x0 = x0_dbl;
                win_y0 = y0_dbl;
                win_w  = w_dbl;
                win_h  = h_dbl;
            end
            default: ;
        endcase

        rel_x     = fb_x - win_x0;  // Wraps when left of the window, caught below
        rel_y     = fb_y - win_y0;
        in_window = (fb_x >= win_x0) && (rel_x < win_w) &&
                    (fb_y >= win_y0) && (rel_y < win_h);

        // Base of the source block behind this output pixel
        case (mode)
            scaler_ctrl_pkg::mode_half_avg: begin
                src_x = scaler_geom_pkg::src_x_t'(rel_x << 1);
                src_y = scaler_geom_pkg::src_y_t'(rel_y << 1);
            end
            scaler_ctrl_pkg::mode_double_rep: begin
                src_x = scaler_geom_pkg::src_x_t'(rel_x >> 1);
                src_y = scaler_geom_pkg::src_y_t'(rel_y >> 1);
            end
            default: begin
                src_x = scaler_geom_pkg::src_x_t'(rel_x);
                src_y = scaler_geom_pkg::src_y_t'(rel_y);
            end
        endcase
    end

endmodule

`default_nettype wire

/* block_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module block_fetch #(
    parameter int src_w = 160
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                start,
    input  wire scaler_ctrl_pkg::scale_mode_t  mode,
    input  wire scaler_geom_pkg::src_x_t       src_x,
    input  wire scaler_geom_pkg::src_y_t       src_y,
    output scaler_geom_pkg::src_addr_t         rom_addr,
    input  wire scaler_geom_pkg::pixel_t       rom_data,
    output scaler_geom_pkg::pixel_t            pixel,
    output logic                               valid
);

    logic busy;
    logic addr_live;                        // rom_addr holds a tap this cycle
    logic data_live;                        // rom_data holds that tap's pixel
    logic last_tap;
    scaler_ctrl_pkg::tap_cnt_t taps_q;
    scaler_ctrl_pkg::tap_cnt_t issue_cnt;   // Next tap to issue, bit0 = dx, bit1 = dy
    scaler_ctrl_pkg::tap_cnt_t recv_cnt;
    scaler_geom_pkg::src_x_t   base_x;
    scaler_geom_pkg::src_y_t   base_y;
    scaler_geom_pkg::src_x_t   tap_x;
    scaler_geom_pkg::src_y_t   tap_y;
    logic [9:0] acc;                        // Holds up to 4 x 255
    logic [9:0] sum_next;
    logic [9:0] sum_round;

    function automatic scaler_geom_pkg::src_addr_t tap_addr(
        input scaler_geom_pkg::src_x_t x,
        input scaler_geom_pkg::src_y_t y
    );
        return scaler_geom_pkg::src_addr_t'(y) * scaler_geom_pkg::src_addr_t'(src_w)
             + scaler_geom_pkg::src_addr_t'(x);
    endfunction

    assign tap_x     = base_x + scaler_geom_pkg::src_x_t'(issue_cnt[0]);
    assign tap_y     = base_y + scaler_geom_pkg::src_y_t'(issue_cnt[1]);
    assign last_tap  = data_live && (recv_cnt == taps_q - 3'd1);
    assign sum_next  = acc + {2'b00, rom_data};
    assign sum_round = sum_next + 10'd2;    // Round half up before the divide by 4

    // ========================================
    // Tap sequencing
    // ========================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            addr_live <= 1'b0;
            data_live <= 1'b0;
            valid     <= 1'b0;
            taps_q    <= '0;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            rom_addr  <= '0;
        end else begin
            valid     <= 1'b0;
            data_live <= addr_live;         // ROM answers one cycle later
            if (start) begin
                busy      <= 1'b1;
                taps_q    <= scaler_ctrl_pkg::mode_taps(mode);
                rom_addr  <= tap_addr(src_x, src_y);    // Tap 0 straight from the inputs
                addr_live <= 1'b1;
                issue_cnt <= 3'd1;
                recv_cnt  <= '0;
            end else if (busy) begin
                if (issue_cnt < taps_q) begin
                    rom_addr  <= tap_addr(tap_x, tap_y);
                    addr_live <= 1'b1;
                    issue_cnt <= issue_cnt + 3'd1;
                end else begin
                    addr_live <= 1'b0;
                end
                if (data_live) begin
                    recv_cnt <= recv_cnt + 3'd1;
                end
                if (last_tap) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            base_x <= src_x;
            base_y <= src_y;
            acc    <= '0;
        end else if (data_live) begin
            acc <= sum_next;
        end
        if (last_tap) begin
            pixel <= (taps_q == scaler_ctrl_pkg::taps_block) ? sum_round[9:2] : rom_data;
        end
    end

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    ) else $error("block_fetch got start while a fetch was in flight");

endmodule

`default_nettype wire

/* scale_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module scale_ctrl (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                start,
    input  wire scaler_ctrl_pkg::scale_mode_t  mode,
    output scaler_ctrl_pkg::scale_mode_t       mode_q,
    input  wire scaler_geom_pkg::fb_addr_t     fb_addr_in,
    input  wire                                in_window,
    input  wire                                scan_last,
    output logic                               scan_clear,
    output logic                               scan_step,
    output logic                               fetch_start,
    input  wire scaler_geom_pkg::pixel_t       fetch_pixel,
    input  wire                                fetch_valid,
    output scaler_geom_pkg::fb_addr_t          fb_addr,
    output scaler_geom_pkg::pixel_t            fb_data,
    output logic                               fb_wren,
    output logic                               done
);

    typedef enum logic [2:0] {
        st_idle,
        st_eval,    // Current address judged against the window
        st_fetch,   // Waiting on block_fetch
        st_write,   // Fetched pixel on the framebuffer bus
        st_done
    } state_t;

    state_t state;
    logic   accept;
    logic   black_wr;
    logic   pixel_wr;

    assign accept      = start && (state == st_idle || state == st_done);
    assign scan_clear  = accept;
    assign black_wr    = (state == st_eval) && !in_window;
    assign pixel_wr    = (state == st_fetch) && fetch_valid;
    assign fetch_start = (state == st_eval) && in_window;
    assign scan_step   = !scan_last && (black_wr || (state == st_write));

    // ========================================
    // Frame FSM
    // ========================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            mode_q  <= scaler_ctrl_pkg::mode_normal;
            fb_wren <= 1'b0;
            done    <= 1'b0;
        end else begin
            fb_wren <= black_wr || pixel_wr;
            case (state)
                st_idle, st_done: begin
                    if (accept) begin
                        mode_q <= mode;
                        done   <= 1'b0;
                        state  <= st_eval;
                    end else if (state == st_done) begin
                        done <= 1'b1;   // Rises the cycle after the last write
                    end
                end
                st_eval: begin
                    if (in_window) begin
                        state <= st_fetch;
                    end else if (scan_last) begin
                        state <= st_done;
                    end
                end
                st_fetch: begin
                    if (fetch_valid) begin
                        state <= st_write;
                    end
                end
                st_write: state <= scan_last ? st_done : st_eval;
                default:  state <= st_idle;
            endcase
        end
    end

    // Write data, registered alongside fb_wren
    always_ff @(posedge clk) begin
        if (black_wr) begin
            fb_addr <= fb_addr_in;
            fb_data <= scaler_geom_pkg::pixel_black;
        end else if (pixel_wr) begin
            fb_addr <= fb_addr_in;
            fb_data <= fetch_pixel;
        end
    end

    a_no_write_idle: assert property (
        @(posedge clk) disable iff (reset) (state == st_idle) |-> !fb_wren
    ) else $error("scale_ctrl wrote the framebuffer while idle");

endmodule

`default_nettype wire

/* scaler_top.sv */
`timescale 1ns/100ps
`default_nettype none

module scaler_top #(
    parameter int src_w = 160,
    parameter int src_h = 120,
    parameter int fb_w  = 640,
    parameter int fb_h  = 480
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                start,
    input  wire scaler_ctrl_pkg::scale_mode_t  mode,
    output scaler_geom_pkg::src_addr_t         rom_addr,
    input  wire scaler_geom_pkg::pixel_t       rom_data,
    output scaler_geom_pkg::fb_addr_t          fb_addr,
    output scaler_geom_pkg::pixel_t            fb_data,
    output logic                               fb_wren,
    output logic                               done
);

    scaler_ctrl_pkg::scale_mode_t mode_q;
    scaler_geom_pkg::fb_x_t       fb_x;
    scaler_geom_pkg::fb_y_t       fb_y;
    scaler_geom_pkg::fb_addr_t    scan_addr;
    scaler_geom_pkg::src_x_t      src_x;
    scaler_geom_pkg::src_y_t      src_y;
    scaler_geom_pkg::pixel_t      fetch_pixel;
    logic scan_clear, scan_step, scan_last;
    logic in_window;
    logic fetch_start, fetch_valid;

    raster_scan #(.fb_w(fb_w), .fb_h(fb_h)) u_scan (
        .clk     (clk),
        .reset   (reset),
        .clear   (scan_clear),
        .step    (scan_step),
        .fb_x    (fb_x),
        .fb_y    (fb_y),
        .fb_addr (scan_addr),
        .last    (scan_last)
    );

    source_mapper #(.src_w(src_w), .src_h(src_h), .fb_w(fb_w), .fb_h(fb_h)) u_mapper (
        .fb_x      (fb_x),
        .fb_y      (fb_y),
        .mode      (mode_q),
        .in_window (in_window),
        .src_x     (src_x),
        .src_y     (src_y)
    );

    block_fetch #(.src_w(src_w)) u_fetch (
        .clk      (clk),
        .reset    (reset),
        .start    (fetch_start),
        .mode     (mode_q),
        .src_x    (src_x),
        .src_y    (src_y),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pixel    (fetch_pixel),
        .valid    (fetch_valid)
    );

    scale_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .mode        (mode),
        .mode_q      (mode_q),
        .fb_addr_in  (scan_addr),
        .in_window   (in_window),
        .scan_last   (scan_last),
        .scan_clear  (scan_clear),
        .scan_step   (scan_step),
        .fetch_start (fetch_start),
        .fetch_pixel (fetch_pixel),
        .fetch_valid (fetch_valid),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_wren     (fb_wren),
        .done        (done)
    );

endmodule

`default_nettype wire

/* tb_image_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_image_rom (
    input  wire                          clk,
    input  wire scaler_geom_pkg::src_addr_t addr,
    output scaler_geom_pkg::pixel_t      data
);

    // ========================================
    // Source image, one read cycle of latency
    // ========================================

    // Each address holds the low 8 bits of address * 7 + 3
    always_ff @(posedge clk) begin
        data <= scaler_geom_pkg::pixel_t'(int'(addr) * 7 + 3);
    end

endmodule

`default_nettype wire

/* tb_scaler.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_scaler;

    localparam int src_w       = 16;
    localparam int src_h       = 12;
    localparam int fb_w        = 64;
    localparam int fb_h        = 48;
    localparam int frame_total = fb_w * fb_h;
    localparam int frame_limit = 20000;     // Cycles allowed for one frame

    logic                         clk;
    logic                         reset;
    logic                         start;
    scaler_ctrl_pkg::scale_mode_t mode;
    scaler_geom_pkg::src_addr_t   rom_addr;
    scaler_geom_pkg::pixel_t      rom_data;
    scaler_geom_pkg::fb_addr_t    fb_addr;
    scaler_geom_pkg::pixel_t      fb_data;
    logic                         fb_wren;
    logic                         done;

    int                      frame_mode;    // Mode given with the last start
    logic                    started;
    logic                    timed_out;
    int                      next_addr;     // Address the next write must carry
    int                      tests_run;
    scaler_geom_pkg::pixel_t exp_data;
    int err_quiet = 0;
    int err_order = 0;
    int err_data  = 0;
    int err_done  = 0;
    int err_clear = 0;

    scaler_top #(.src_w(src_w), .src_h(src_h), .fb_w(fb_w), .fb_h(fb_h)) dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .mode     (mode),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .fb_addr  (fb_addr),
        .fb_data  (fb_data),
        .fb_wren  (fb_wren),
        .done     (done)
    );

    tb_image_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Reference model
    // ========================================

    function automatic scaler_geom_pkg::pixel_t rom_value(input int sx, input int sy);
        return scaler_geom_pkg::pixel_t'((sy * src_w + sx) * 7 + 3);
    endfunction

    // Expected framebuffer value at a linear address for a mode code
    function automatic scaler_geom_pkg::pixel_t ref_pixel(input int addr, input int m);
        int ww;
        int wh;
        int rx;
        int ry;
        int sum;
        ww = src_w;
        wh = src_h;
        if (m == 1) begin
            ww = src_w / 2;
            wh = src_h / 2;
        end else if (m == 2) begin
            ww = src_w * 2;
            wh = src_h * 2;
        end
        rx = addr % fb_w - (fb_w - ww) / 2;     // Offset inside the centred window
        ry = addr / fb_w - (fb_h - wh) / 2;
        if (rx < 0 || rx >= ww || ry < 0 || ry >= wh) begin
            return 8'h00;
        end
        if (m == 1) begin
            sum = rom_value(2 * rx, 2 * ry) + rom_value(2 * rx + 1, 2 * ry)
                + rom_value(2 * rx, 2 * ry + 1) + rom_value(2 * rx + 1, 2 * ry + 1);
            return scaler_geom_pkg::pixel_t'((sum + 2) / 4);
        end
        if (m == 2) begin
            return rom_value(rx / 2, ry / 2);
        end
        return rom_value(rx, ry);
    endfunction

    function automatic int total_errors();
        return err_quiet + err_order + err_data + err_done + err_clear;
    endfunction

    always_comb exp_data = ref_pixel(int'(fb_addr), frame_mode);

    // Write counter that restarts with each start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            next_addr <= 0;
        end else if (start) begin
            next_addr <= 0;
        end else if (fb_wren) begin
            next_addr <= next_addr + 1;
        end
    end

    // ========================================
    // Checks
    // ========================================

    a_quiet_until_start: assert property (
        @(posedge clk) disable iff (reset) !started |-> (!fb_wren && !done)
    ) else begin
        $display("ERR %0t fb_wren/done expected 0/0 got %0b/%0b",
                 $time, $sampled(fb_wren), $sampled(done));
        err_quiet++;
    end

    a_write_order: assert property (
        @(posedge clk) disable iff (reset) fb_wren |-> (int'(fb_addr) == next_addr)
    ) else begin
        $display("ERR %0t fb_addr expected %0d got %0d",
                 $time, $sampled(next_addr), $sampled(fb_addr));
        err_order++;
    end

    a_write_data: assert property (
        @(posedge clk) disable iff (reset) fb_wren |-> (fb_data == exp_data)
    ) else begin
        $display("ERR %0t fb_data expected %02h got %02h",
                 $time, $sampled(exp_data), $sampled(fb_data));
        err_data++;
    end

    // done only once every address got its write and no write follows
    a_done_after_last: assert property (
        @(posedge clk) disable iff (reset) done |-> (next_addr == frame_total && !fb_wren)
    ) else begin
        $display("ERR %0t write count expected %0d got %0d",
                 $time, frame_total, $sampled(next_addr));
        err_done++;
    end

    a_start_clears_done: assert property (
        @(posedge clk) disable iff (reset) (start && done) |=> !done
    ) else begin
        $display("ERR %0t done expected 0 got %0b", $time, $sampled(done));
        err_clear++;
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic pulse_start(input int m);
        @(negedge clk);
        mode       = scaler_ctrl_pkg::scale_mode_t'(m);
        frame_mode = m;
        start      = 1'b1;
        started    = 1'b1;
        @(negedge clk);
        start      = 1'b0;
        mode       = scaler_ctrl_pkg::scale_mode_t'((m + 2) % 4);  // Ignored until next start
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done && cycles < frame_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("%s: done never came within %0d cycles", name, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input int m, input string name);
        int errs_before;
        errs_before = total_errors();
        pulse_start(m);
        wait_done(name);
        tests_run++;
        $display("%s: mode %0d, %0d writes, %0d errors",
                 name, m, next_addr, total_errors() - errs_before);
    endtask

    initial begin
        int m;
        int prev;
        void'($urandom(70769));
        reset      = 1'b1;
        start      = 1'b0;
        mode       = scaler_ctrl_pkg::mode_normal;
        frame_mode = 0;
        started    = 1'b0;
        timed_out  = 1'b0;
        tests_run  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle stretch with no start
        repeat ($urandom_range(5, 20)) @(negedge clk);
        tests_run++;
        $display("reset_quiet: %0d errors", total_errors());

        run_frame(0, "frame_normal");
        if (!timed_out) run_frame(1, "frame_half");
        if (!timed_out) run_frame(2, "frame_double");

        // Restart from done with a mode that differs from the frame before
        prev = 2;
        for (int i = 0; i < 4 && !timed_out; i++) begin
            m = (prev + 1 + int'($urandom_range(0, 2))) % 4;
            repeat ($urandom_range(0, 6)) @(negedge clk);
            run_frame(m, $sformatf("back_to_back_%0d", i));
            prev = m;
        end

        $display("%0d tests, %0d failed checks", tests_run, total_errors());
        if (timed_out || total_errors() != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* scaler.f */
scaler_geom_pkg.sv
scaler_ctrl_pkg.sv
raster_scan.sv
source_mapper.sv
block_fetch.sv
scale_ctrl.sv
scaler_top.sv
tb_image_rom.sv
tb_scaler.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_scaler
FILELIST = scaler.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The log decides pass or fail, not the simulator's exit status
run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
